// ==== rtl/dx_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, constants, vector types and bundles for the decode to
// execute stage; import into modules and the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package dx_pkg;

  //////////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////////

  localparam int OPERAND_WIDTH = 32;
  localparam int RF_ADDR_WIDTH = 5;
  localparam int OPCODE_WIDTH  = 6;
  localparam int ALU_OPC_WIDTH = 4;
  localparam int IMM_WIDTH     = 16;
  localparam int IMMJBR_WIDTH  = 10;

  //////////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [OPERAND_WIDTH-1:0] operand_t;
  typedef logic [RF_ADDR_WIDTH-1:0] rf_adr_t;
  typedef logic [OPCODE_WIDTH-1:0]  opcode_t;
  typedef logic [ALU_OPC_WIDTH-1:0] alu_opc_t;
  typedef logic [IMM_WIDTH-1:0]     imm16_t;
  typedef logic [IMMJBR_WIDTH-1:0]  immjbr_t;
  typedef logic [1:0]               lsu_len_t;

  // l.nop major opcode, loaded whenever execute holds no instruction
  localparam opcode_t OPCODE_NOP = 6'h05;

  // delay slot is always present, so sequential flow resumes at pc + 8
  localparam operand_t NEXT_PC_OFFSET = 32'd8;

  //////////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////////

  // operation flags, cleared by reset, flush and bubble
  typedef struct packed {
    logic rf_wb;
    logic alu;
    logic add;
    logic div;
    logic shift;
    logic setflag;
    logic jbr;
    logic jr;
    logic jal;
    logic bf;
    logic bnf;
    logic brcond;
    logic branch;
    logic lsu_load;
    logic lsu_store;
    logic lsu_atomic;
    logic mfspr;
    logic mtspr;
    logic rfe;
  } dx_ops_t;

  // operand fields, loaded on every advance
  typedef struct packed {
    alu_opc_t opc_alu;
    imm16_t   imm16;
    operand_t immediate;
    logic     immediate_sel;
    immjbr_t  immjbr_upper;
    lsu_len_t lsu_length;
    logic     lsu_zext;
    rf_adr_t  rfd_adr;
  } dx_payload_t;

  typedef struct packed {
    logic ibus_err;
    logic illegal;
    logic syscall;
    logic trap;
    logic ibus_align;
  } dx_except_t;

  // what the control stage holds, for the jr interlock
  typedef struct packed {
    logic    op_lsu_load;
    logic    op_mfspr;
    rf_adr_t rfd_adr;
  } dx_ctrl_use_t;

endpackage

`default_nettype wire

// ==== rtl/dx_hazard_detect.sv ====
////////////////////////////////////////////////////////////////////////////
// interlock logic, decides when decode must push a bubble into execute
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dx_hazard_detect (
  input  wire logic                 padv_i,
  input  wire dx_pkg::dx_ops_t      decode_ops_i,
  input  wire dx_pkg::rf_adr_t      decode_rfa_adr_i,
  input  wire dx_pkg::rf_adr_t      decode_rfb_adr_i,
  input  wire dx_pkg::dx_ops_t      execute_ops_i,
  input  wire dx_pkg::rf_adr_t      execute_rfd_adr_i,
  input  wire dx_pkg::dx_ctrl_use_t ctrl_use_i,
  output logic                      decode_bubble_o,
  output logic                      jr_stall_o
);

  logic exe_rfa_hit;
  logic exe_rfb_hit;
  logic ctrl_interlock;
  logic exe_load_use;
  logic exe_atomic_store;

  // decode source registers against the execute destination
  assign exe_rfa_hit = (decode_rfa_adr_i == execute_rfd_adr_i);
  assign exe_rfb_hit = (decode_rfb_adr_i == execute_rfd_adr_i);

  // result of a load or mfspr in control is not yet written back
  assign ctrl_interlock = (ctrl_use_i.op_lsu_load | ctrl_use_i.op_mfspr) &
                          ((decode_rfa_adr_i == ctrl_use_i.rfd_adr) |
                           (decode_rfb_adr_i == ctrl_use_i.rfd_adr));

  // load and mfspr results only appear in control stage
  assign exe_load_use = (execute_ops_i.lsu_load | execute_ops_i.mfspr) &
                        (exe_rfa_hit | exe_rfb_hit);

  // jr reads its target in decode, so any pending write to rfb stalls it
  assign jr_stall_o = decode_ops_i.jr &
                      (ctrl_interlock | (execute_ops_i.rf_wb & exe_rfb_hit));

  assign exe_atomic_store = execute_ops_i.lsu_store & execute_ops_i.lsu_atomic;

  // rfe bubbles to hold fetch while it travels to control
  assign decode_bubble_o = padv_i &
                           (exe_load_use | jr_stall_o | exe_atomic_store |
                            decode_ops_i.rfe);

endmodule

`default_nettype wire

// ==== rtl/dx_branch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// early branch detection in decode, computes the taken target, the
// mispredict target and the link value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dx_branch_unit (
  input  wire logic                pipeline_flush_i,
  input  wire logic                predicted_flag_i,
  input  wire dx_pkg::operand_t    pc_decode_i,
  input  wire dx_pkg::opcode_t     decode_opc_insn_i,
  input  wire dx_pkg::dx_ops_t     decode_ops_i,
  input  wire dx_pkg::dx_payload_t decode_payload_i,
  input  wire logic                jr_stall_i,
  input  wire dx_pkg::operand_t    decode_rfb_i,
  input  wire dx_pkg::operand_t    execute_rfb_i,
  input  wire logic                execute_bubble_i,
  input  wire logic                execute_jr_i,
  output logic                     decode_branch_o,
  output dx_pkg::operand_t         decode_branch_target_o,
  output dx_pkg::operand_t         mispredict_target_o,
  output dx_pkg::operand_t         jal_result_o,
  output logic                     ibus_align_o
);

  import dx_pkg::*;

  localparam int EXT_WIDTH = OPERAND_WIDTH - IMMJBR_WIDTH - IMM_WIDTH - 2;

  logic     branch_to_imm;
  logic     branch_to_reg;
  logic     mispredicted;
  operand_t imm_offset;
  operand_t imm_target;
  operand_t reg_target;
  operand_t next_pc;

  //////////////////////////////////////////////////////////////////////////
  // immediate branches
  //////////////////////////////////////////////////////////////////////////

  // l.j / l.jal have opcode bits 2:1 clear, l.bf / l.bnf use bit 2
  assign branch_to_imm = decode_ops_i.jbr &
                         (~(|decode_opc_insn_i[2:1]) |
                          (decode_opc_insn_i[2] == predicted_flag_i));

  // word offset, sign extended to a full address
  assign imm_offset = {{EXT_WIDTH{decode_payload_i.immjbr_upper[IMMJBR_WIDTH-1]}},
                       decode_payload_i.immjbr_upper,
                       decode_payload_i.imm16,
                       2'b00};

  assign imm_target = pc_decode_i + imm_offset;

  //////////////////////////////////////////////////////////////////////////
  // register branches
  //////////////////////////////////////////////////////////////////////////

  assign branch_to_reg = decode_ops_i.jr & ~jr_stall_i;

  // after a bubble or a jr, the target register comes from execute
  assign reg_target = (execute_bubble_i | execute_jr_i) ? execute_rfb_i : decode_rfb_i;

  assign decode_branch_o        = (branch_to_imm | branch_to_reg) & ~pipeline_flush_i;
  assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;

  // instruction fetch from a misaligned target
  assign ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

  //////////////////////////////////////////////////////////////////////////
  // mispredict and link
  //////////////////////////////////////////////////////////////////////////

  assign next_pc = pc_decode_i + NEXT_PC_OFFSET;

  // prediction went the other way, so recovery must take the branch
  assign mispredicted = (decode_ops_i.bf & ~predicted_flag_i) |
                        (decode_ops_i.bnf & predicted_flag_i);

  assign mispredict_target_o = mispredicted ? imm_target : next_pc;
  assign jal_result_o        = next_pc;

endmodule

`default_nettype wire

// ==== rtl/dx_stage_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// execute stage pipeline registers; flags obey reset, flush and bubble,
// operand fields simply follow the pipeline advance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dx_stage_regs (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                padv_i,
  input  wire logic                pipeline_flush_i,
  input  wire logic                decode_bubble_i,
  input  wire dx_pkg::dx_ops_t     decode_ops_i,
  input  wire dx_pkg::dx_payload_t decode_payload_i,
  input  wire dx_pkg::dx_except_t  decode_except_i,
  input  wire dx_pkg::opcode_t     decode_opc_insn_i,
  input  wire dx_pkg::operand_t    pc_decode_i,
  input  wire logic                ibus_align_i,
  input  wire logic                predicted_flag_i,
  input  wire dx_pkg::operand_t    mispredict_target_i,
  input  wire dx_pkg::operand_t    jal_result_i,
  output dx_pkg::dx_ops_t          execute_ops_o,
  output dx_pkg::dx_payload_t      execute_payload_o,
  output dx_pkg::dx_except_t       execute_except_o,
  output dx_pkg::opcode_t          execute_opc_insn_o,
  output dx_pkg::operand_t         pc_execute_o,
  output dx_pkg::operand_t         execute_mispredict_target_o,
  output dx_pkg::operand_t         execute_jal_result_o,
  output logic                     execute_predicted_flag_o,
  output logic                     execute_bubble_o,
  output logic                     decode_valid_o
);

  import dx_pkg::*;

  dx_ops_t    bubble_ops;
  dx_except_t except_next;

  // a bubble is a nop, except that rfe must still reach control stage;
  // the flush that rfe raises later clears it
  always_comb begin
    bubble_ops     = '0;
    bubble_ops.rfe = decode_ops_i.rfe;
  end

  always_comb begin
    except_next            = decode_except_i;
    except_next.ibus_align = ibus_align_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_ops_o      <= '0;
      execute_opc_insn_o <= OPCODE_NOP;
      execute_bubble_o   <= 1'b0;
    end else if (pipeline_flush_i) begin
      execute_ops_o      <= '0;
      execute_opc_insn_o <= OPCODE_NOP;
      execute_bubble_o   <= 1'b0;
    end else if (padv_i) begin
      execute_ops_o      <= decode_bubble_i ? bubble_ops : decode_ops_i;
      execute_opc_insn_o <= decode_bubble_i ? OPCODE_NOP : decode_opc_insn_i;
      execute_bubble_o   <= decode_bubble_i;
    end
  end

  // exceptions are not flushed, the control stage qualifies them
  always_ff @(posedge clk) begin
    if (rst) begin
      execute_except_o <= '0;
    end else if (padv_i) begin
      execute_except_o <= except_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_valid_o <= 1'b0;
    end else begin
      decode_valid_o <= padv_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (padv_i) begin
      execute_payload_o    <= decode_payload_i;
      pc_execute_o         <= pc_decode_i;
      execute_jal_result_o <= jal_result_i;
    end
  end

  // prediction state only matters for conditional branches
  always_ff @(posedge clk) begin
    if (padv_i & decode_ops_i.brcond) begin
      execute_predicted_flag_o    <= predicted_flag_i;
      execute_mispredict_target_o <= mispredict_target_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decode_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// decode to execute stage top, ties hazard detection, branch unit and
// the execute registers together
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module decode_execute (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 padv_i,
  input  wire logic                 pipeline_flush_i,
  input  wire dx_pkg::operand_t     pc_decode_i,
  input  wire logic                 predicted_flag_i,
  input  wire dx_pkg::rf_adr_t      decode_rfa_adr_i,
  input  wire dx_pkg::rf_adr_t      decode_rfb_adr_i,
  input  wire dx_pkg::operand_t     decode_rfb_i,
  input  wire dx_pkg::operand_t     execute_rfb_i,
  input  wire dx_pkg::opcode_t      decode_opc_insn_i,
  input  wire dx_pkg::dx_ops_t      decode_ops_i,
  input  wire dx_pkg::dx_payload_t  decode_payload_i,
  input  wire dx_pkg::dx_except_t   decode_except_i,
  input  wire dx_pkg::dx_ctrl_use_t ctrl_use_i,
  output logic                      decode_bubble_o,
  output logic                      decode_branch_o,
  output dx_pkg::operand_t          decode_branch_target_o,
  output dx_pkg::dx_ops_t           execute_ops_o,
  output dx_pkg::dx_payload_t       execute_payload_o,
  output dx_pkg::dx_except_t        execute_except_o,
  output dx_pkg::opcode_t           execute_opc_insn_o,
  output dx_pkg::operand_t          pc_execute_o,
  output dx_pkg::operand_t          execute_mispredict_target_o,
  output dx_pkg::operand_t          execute_jal_result_o,
  output logic                      execute_predicted_flag_o,
  output logic                      execute_bubble_o,
  output logic                      decode_valid_o
);

  import dx_pkg::*;

  logic     jr_stall;
  logic     ibus_align;
  operand_t mispredict_target;
  operand_t jal_result;

  dx_hazard_detect i_dx_hazard_detect (
    .padv_i            (padv_i),
    .decode_ops_i      (decode_ops_i),
    .decode_rfa_adr_i  (decode_rfa_adr_i),
    .decode_rfb_adr_i  (decode_rfb_adr_i),
    .execute_ops_i     (execute_ops_o),
    .execute_rfd_adr_i (execute_payload_o.rfd_adr),
    .ctrl_use_i        (ctrl_use_i),
    .decode_bubble_o   (decode_bubble_o),
    .jr_stall_o        (jr_stall)
  );

  dx_branch_unit i_dx_branch_unit (
    .pipeline_flush_i       (pipeline_flush_i),
    .predicted_flag_i       (predicted_flag_i),
    .pc_decode_i            (pc_decode_i),
    .decode_opc_insn_i      (decode_opc_insn_i),
    .decode_ops_i           (decode_ops_i),
    .decode_payload_i       (decode_payload_i),
    .jr_stall_i             (jr_stall),
    .decode_rfb_i           (decode_rfb_i),
    .execute_rfb_i          (execute_rfb_i),
    .execute_bubble_i       (execute_bubble_o),
    .execute_jr_i           (execute_ops_o.jr),
    .decode_branch_o        (decode_branch_o),
    .decode_branch_target_o (decode_branch_target_o),
    .mispredict_target_o    (mispredict_target),
    .jal_result_o           (jal_result),
    .ibus_align_o           (ibus_align)
  );

  dx_stage_regs i_dx_stage_regs (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (padv_i),
    .pipeline_flush_i            (pipeline_flush_i),
    .decode_bubble_i             (decode_bubble_o),
    .decode_ops_i                (decode_ops_i),
    .decode_payload_i            (decode_payload_i),
    .decode_except_i             (decode_except_i),
    .decode_opc_insn_i           (decode_opc_insn_i),
    .pc_decode_i                 (pc_decode_i),
    .ibus_align_i                (ibus_align),
    .predicted_flag_i            (predicted_flag_i),
    .mispredict_target_i         (mispredict_target),
    .jal_result_i                (jal_result),
    .execute_ops_o               (execute_ops_o),
    .execute_payload_o           (execute_payload_o),
    .execute_except_o            (execute_except_o),
    .execute_opc_insn_o          (execute_opc_insn_o),
    .pc_execute_o                (pc_execute_o),
    .execute_mispredict_target_o (execute_mispredict_target_o),
    .execute_jal_result_o        (execute_jal_result_o),
    .execute_predicted_flag_o    (execute_predicted_flag_o),
    .execute_bubble_o            (execute_bubble_o),
    .decode_valid_o              (decode_valid_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_dx_model.svh ====
////////////////////////////////////////////////////////////////////////////
// reference model of the decode to execute stage; included at the end of
// the testbench module body, uses its stimulus and state bundles
////////////////////////////////////////////////////////////////////////////

`ifndef TB_DX_MODEL_SVH
`define TB_DX_MODEL_SVH

function automatic exe_state_t model_reset();
  exe_state_t e;
  e     = '0;
  e.opc = OPCODE_NOP;
  return e;
endfunction

// combinational decode outputs from the present inputs and execute state
function automatic comb_exp_t model_decode(input stim_t s, input exe_state_t e);
  comb_exp_t c;
  logic      ctrl_hit;
  logic      jr_stall;
  logic      load_use;
  logic      imm_branch;
  logic      reg_branch;
  logic      mispred;
  logic [27:0] word_offset;
  operand_t  offset;
  operand_t  imm_target;
  operand_t  reg_target;
  ctrl_hit = (s.ctrl_use.op_lsu_load || s.ctrl_use.op_mfspr) &&
             (s.rfa == s.ctrl_use.rfd_adr || s.rfb == s.ctrl_use.rfd_adr);
  jr_stall = s.ops.jr && (ctrl_hit || (e.ops.rf_wb && s.rfb == e.payload.rfd_adr));
  load_use = (e.ops.lsu_load || e.ops.mfspr) &&
             (s.rfa == e.payload.rfd_adr || s.rfb == e.payload.rfd_adr);
  c.bubble = s.padv && (load_use || jr_stall || s.ops.rfe ||
                        (e.ops.lsu_store && e.ops.lsu_atomic));

  // conditional forms are taken when opcode bit 2 agrees with the prediction
  imm_branch  = s.ops.jbr && (s.opc[2:1] == 2'b00 || s.opc[2] == s.pred);
  word_offset = {s.payload.immjbr_upper, s.payload.imm16, 2'b00};
  offset      = word_offset[27] ? {4'hf, word_offset} : {4'h0, word_offset};
  imm_target  = s.pc + offset;

  reg_branch = s.ops.jr && !jr_stall;
  reg_target = (e.bubble || e.ops.jr) ? s.execute_rfb : s.decode_rfb;

  c.branch     = (imm_branch || reg_branch) && !s.flush;
  c.target     = imm_branch ? imm_target : reg_target;
  c.ibus_align = c.branch && (c.target[1:0] != 2'b00);
  mispred      = (s.ops.bf && !s.pred) || (s.ops.bnf && s.pred);
  c.jal        = s.pc + NEXT_PC_OFFSET;
  c.mispredict = mispred ? imm_target : c.jal;
  return c;
endfunction

// execute state after the next clock edge
function automatic exe_state_t model_advance(input stim_t s, input exe_state_t e,
                                             input comb_exp_t c);
  exe_state_t n;
  n       = e;
  n.valid = s.padv;
  if (s.flush) begin
    n.ops    = '0;
    n.opc    = OPCODE_NOP;
    n.bubble = 1'b0;
  end else if (s.padv) begin
    n.ops        = c.bubble ? dx_ops_t'('0) : s.ops;
    n.ops.rfe    = s.ops.rfe;
    n.opc        = c.bubble ? OPCODE_NOP : s.opc;
    n.bubble     = c.bubble;
  end
  if (s.padv) begin
    n.except            = s.except;
    n.except.ibus_align = c.ibus_align;
    n.payload           = s.payload;
    n.pc                = s.pc;
    n.jal               = c.jal;
    n.payload_loaded    = 1'b1;
    if (s.ops.brcond) begin
      n.pred        = s.pred;
      n.mispredict  = c.mispredict;
      n.pred_loaded = 1'b1;
    end
  end
  return n;
endfunction

`endif

// ==== testbench/tb_decode_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// random testbench for the decode to execute stage, every output is
// compared with the reference model on each rising edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_decode_execute;

  import dx_pkg::*;

  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;

  typedef struct packed {
    logic         padv;
    logic         flush;
    operand_t     pc;
    logic         pred;
    rf_adr_t      rfa;
    rf_adr_t      rfb;
    operand_t     decode_rfb;
    operand_t     execute_rfb;
    opcode_t      opc;
    dx_ops_t      ops;
    dx_payload_t  payload;
    dx_except_t   except;
    dx_ctrl_use_t ctrl_use;
  } stim_t;

  // expected execute registers, plus first-load tracking for unreset ones
  typedef struct packed {
    dx_ops_t     ops;
    dx_payload_t payload;
    dx_except_t  except;
    opcode_t     opc;
    operand_t    pc;
    operand_t    mispredict;
    operand_t    jal;
    logic        pred;
    logic        bubble;
    logic        valid;
    logic        payload_loaded;
    logic        pred_loaded;
  } exe_state_t;

  typedef struct packed {
    logic     bubble;
    logic     branch;
    operand_t target;
    logic     ibus_align;
    operand_t mispredict;
    operand_t jal;
  } comb_exp_t;

  logic        clk;
  logic        rst;
  stim_t       stim;
  exe_state_t  model;
  comb_exp_t   exp_comb;
  integer      seed = 61130;
  int          cycles = 0;

  logic        decode_bubble;
  logic        decode_branch;
  operand_t    decode_branch_target;
  dx_ops_t     execute_ops;
  dx_payload_t execute_payload;
  dx_except_t  execute_except;
  opcode_t     execute_opc_insn;
  operand_t    pc_execute;
  operand_t    execute_mispredict_target;
  operand_t    execute_jal_result;
  logic        execute_predicted_flag;
  logic        execute_bubble;
  logic        decode_valid;

  decode_execute i_decode_execute (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (stim.padv),
    .pipeline_flush_i            (stim.flush),
    .pc_decode_i                 (stim.pc),
    .predicted_flag_i            (stim.pred),
    .decode_rfa_adr_i            (stim.rfa),
    .decode_rfb_adr_i            (stim.rfb),
    .decode_rfb_i                (stim.decode_rfb),
    .execute_rfb_i               (stim.execute_rfb),
    .decode_opc_insn_i           (stim.opc),
    .decode_ops_i                (stim.ops),
    .decode_payload_i            (stim.payload),
    .decode_except_i             (stim.except),
    .ctrl_use_i                  (stim.ctrl_use),
    .decode_bubble_o             (decode_bubble),
    .decode_branch_o             (decode_branch),
    .decode_branch_target_o      (decode_branch_target),
    .execute_ops_o               (execute_ops),
    .execute_payload_o           (execute_payload),
    .execute_except_o            (execute_except),
    .execute_opc_insn_o          (execute_opc_insn),
    .pc_execute_o                (pc_execute),
    .execute_mispredict_target_o (execute_mispredict_target),
    .execute_jal_result_o        (execute_jal_result),
    .execute_predicted_flag_o    (execute_predicted_flag),
    .execute_bubble_o            (execute_bubble),
    .decode_valid_o              (decode_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // register numbers stay in 0..3 so that hazards show up often
  task automatic draw_stimulus();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    r5 = $random(seed);
    r6 = $random(seed);
    stim.padv                 = (r0[1:0] != 2'b00);
    stim.flush                = (r0[5:2] == 4'd0);
    stim.pred                 = r0[6];
    stim.rfa                  = {3'b000, r0[8:7]};
    stim.rfb                  = {3'b000, r0[10:9]};
    stim.opc                  = r0[16:11];
    stim.ctrl_use.op_lsu_load = r0[17];
    stim.ctrl_use.op_mfspr    = r0[18] & r0[19];
    stim.ctrl_use.rfd_adr     = {3'b000, r0[21:20]};
    stim.ops                  = r1[$bits(dx_ops_t)-1:0];
    // rfe and atomic stores always bubble, keep them rare
    stim.ops.rfe              = (r1[31:28] == 4'd0);
    stim.ops.lsu_atomic       = (r1[27:25] == 3'd0);
    stim.except               = r1[24:20];
    stim.pc                   = r2;
    if (r0[24:23] != 2'b00) begin
      stim.pc[1:0] = 2'b00;
    end
    stim.decode_rfb = r3;
    if (r0[25]) begin
      stim.decode_rfb[1:0] = 2'b00;
    end
    stim.execute_rfb = r6;
    if (r0[26]) begin
      stim.execute_rfb[1:0] = 2'b00;
    end
    stim.payload.immediate     = r4;
    stim.payload.imm16         = r5[15:0];
    stim.payload.immjbr_upper  = r5[25:16];
    stim.payload.opc_alu       = r5[29:26];
    stim.payload.immediate_sel = r5[30];
    stim.payload.lsu_zext      = r5[31];
    stim.payload.lsu_length    = r0[28:27];
    stim.payload.rfd_adr       = {3'b000, r0[30:29]};
  endtask

  initial begin
    rst  = 1'b1;
    stim = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // a few idle cycles with padv low after reset
    repeat (3) @(negedge clk);
    repeat (NUM_CYCLES) begin
      @(negedge clk);
      draw_stimulus();
    end
    @(posedge clk);
    @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_operand(input operand_t got, input operand_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_opcode(input opcode_t got, input opcode_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ops(input dx_ops_t got, input dx_ops_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_except(input dx_except_t got, input dx_except_t exp,
                              input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_payload(input dx_payload_t got, input dx_payload_t exp,
                               input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checker, registered outputs still hold their pre-edge values here
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
    if (rst) begin
      model = model_reset();
    end else begin
      exp_comb = model_decode(stim, model);
      check_bit(decode_bubble, exp_comb.bubble, "decode_bubble_o");
      check_bit(decode_branch, exp_comb.branch, "decode_branch_o");
      check_operand(decode_branch_target, exp_comb.target, "decode_branch_target_o");
      check_bit(decode_valid, model.valid, "decode_valid_o");
      check_bit(execute_bubble, model.bubble, "execute_bubble_o");
      check_ops(execute_ops, model.ops, "execute_ops_o");
      check_except(execute_except, model.except, "execute_except_o");
      check_opcode(execute_opc_insn, model.opc, "execute_opc_insn_o");
      if (model.payload_loaded) begin
        check_payload(execute_payload, model.payload, "execute_payload_o");
        check_operand(pc_execute, model.pc, "pc_execute_o");
        check_operand(execute_jal_result, model.jal, "execute_jal_result_o");
      end
      if (model.pred_loaded) begin
        check_bit(execute_predicted_flag, model.pred, "execute_predicted_flag_o");
        check_operand(execute_mispredict_target, model.mispredict,
                      "execute_mispredict_target_o");
      end
      model = model_advance(stim, model, exp_comb);
    end
  end

  `include "tb_dx_model.svh"

endmodule

`default_nettype wire

// ==== dx_stage.f ====
+incdir+testbench
rtl/dx_pkg.sv
rtl/dx_hazard_detect.sv
rtl/dx_branch_unit.sv
rtl/dx_stage_regs.sv
rtl/decode_execute.sv
testbench/tb_decode_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the decode to execute testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timescale 1ns/1ns --top-module tb_decode_execute \
    -f dx_stage.f -o tb_decode_execute; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_decode_execute > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
